// File: Makefile
TOP := tb_icache_top
LOG := sim.log

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

obj_dir/V$(TOP): build.f $(wildcard hw/*.sv verif/*.sv verif/*.svh)
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only -Wall --top-module icache_top \
		hw/icache_pkg.sv hw/line_array.sv hw/tag_store.sv hw/data_store.sv \
		hw/miss_unit.sv hw/fetch_control.sv hw/icache_top.sv

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
+incdir+verif
hw/icache_pkg.sv
hw/line_array.sv
hw/tag_store.sv
hw/data_store.sv
hw/miss_unit.sv
hw/fetch_control.sv
hw/icache_top.sv
verif/tb_icache_top.sv

// File: hw/data_store.sv
/*
 * line data for both ways, written by a fill
 * hit word selection by pc bit 2
 */

`timescale 1ns/100ps
`default_nettype none

module data_store import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  wire logic  clk,
    input  wire addr_t pc,
    input  wire logic  hit_way,
    input  wire logic  fill_done,
    input  wire addr_t fill_addr,
    input  wire logic  fill_way,
    input  wire fill_t fill_data,
    output inst_t      hit_inst
);

    localparam int DEPTH = 1 << INDEX_W;

    logic [INDEX_W-1:0] pc_idx;
    logic [INDEX_W-1:0] fill_idx;
    fill_t              rd_line [2];
    fill_t              hit_line;

    assign pc_idx   = pc[OFFSET_W +: INDEX_W];
    assign fill_idx = fill_addr[OFFSET_W +: INDEX_W];

    for (genvar w = 0; w < 2; w++) begin : g_way
        line_array #(
            .entry_t (fill_t),
            .DEPTH   (DEPTH)
        ) data_way_inst (
            .clk   (clk),
            .we    (fill_done && (fill_way == 1'(w))),
            .waddr (fill_idx),
            .wdata (fill_data),
            .raddr (pc_idx),
            .rdata (rd_line[w])
        );
    end

    assign hit_line = hit_way ? rd_line[1] : rd_line[0];

    // upper word for pc[2] set
    assign hit_inst = pc[2] ? hit_line[INST_W +: INST_W] : hit_line[0 +: INST_W];

endmodule

`default_nettype wire

// File: hw/fetch_control.sv
/*
 * fetch acceptance, hit pending state and miss wait
 * instruction register, inst_valid and fetch_error
 */

`timescale 1ns/100ps
`default_nettype none

module fetch_control import icache_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  stall,
    input  wire logic  flush,
    input  wire addr_t pc,
    input  wire logic  hit,
    input  wire logic  busy,
    input  wire inst_t hit_inst,
    input  wire logic  fill_done,
    input  wire fill_t fill_data,
    input  wire resp_t rresp,
    output logic       start_miss,
    output logic       abort,
    output inst_t      inst,
    output logic       inst_valid,
    output logic       fetch_error
);

    typedef enum logic [1:0] {
        FC_IDLE,
        FC_HIT,
        FC_MISS
    } fetch_state_t;

    fetch_state_t state_q;
    logic         accept;
    logic         fill_end;
    inst_t        fill_inst;

    // flush only counts while the stage is not stalled
    assign abort      = flush && !stall;
    assign accept     = (state_q == FC_IDLE) && !busy && !stall && !flush;
    assign start_miss = accept && !hit;
    assign fill_end   = (state_q == FC_MISS) && fill_done;
    assign fill_inst  = pc[2] ? fill_data[INST_W +: INST_W] : fill_data[0 +: INST_W];

    // ========================================================================
    // state
    always_ff @(posedge clk) begin
        if (rst || abort) begin
            state_q <= FC_IDLE;
        end else begin
            case (state_q)
                FC_IDLE: begin
                    if (accept) begin
                        state_q <= hit ? FC_HIT : FC_MISS;
                    end
                end
                FC_HIT:  state_q <= FC_IDLE;
                FC_MISS: if (fill_done) state_q <= FC_IDLE;
                default: state_q <= FC_IDLE;
            endcase
        end
    end

    // ========================================================================
    // output instruction
    always_ff @(posedge clk) begin
        if (rst || abort) begin
            inst       <= INST_NOP;
            inst_valid <= 1'b1;
        end else if (accept) begin
            inst_valid <= 1'b0;
        end else if (state_q == FC_HIT) begin
            inst       <= hit_inst;
            inst_valid <= 1'b1;
        end else if (fill_end) begin
            inst       <= fill_inst;
            inst_valid <= 1'b1;
        end
    end

    // sticky until the next fill
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_error <= 1'b0;
        end else if (fill_end) begin
            fetch_error <= (rresp != RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_pkg.sv
/*
 * instruction cache widths, payload types and constants
 * shared by the fetch control, the tag and data stores and the miss unit
 */

`default_nettype none

package icache_pkg;

    // fetch side
    localparam int ADDR_W   = 32;
    localparam int INST_W   = 32;

    // one bus beat carries one whole line
    localparam int FILL_W   = 64;
    localparam int OFFSET_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;
    typedef logic [FILL_W-1:0] fill_t;

    // read response code, as on the bus
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // addi x0, x0, 0
    localparam inst_t INST_NOP  = 32'h0000_0013;

endpackage

`default_nettype wire

// File: hw/icache_top.sv
/*
 * two-way set-associative instruction cache, top level
 * fetch control, tag store, data store and bus miss unit
 */

`timescale 1ns/100ps
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t pc,
    input  wire logic  stall,
    input  wire logic  flush,
    // read address and read data channels
    input  wire logic  arready,
    output logic       arvalid,
    output addr_t      araddr,
    output logic       rready,
    input  wire logic  rvalid,
    input  wire resp_t rresp,
    input  wire fill_t rdata,
    // to decode
    output inst_t      inst,
    output logic       inst_valid,
    output logic       fetch_error
);

    logic  start_miss;
    logic  abort;
    logic  hit;
    logic  hit_way;
    logic  fill_way;
    logic  busy;
    logic  fill_done;
    addr_t fill_addr;
    fill_t fill_data;
    inst_t hit_inst;

    fetch_control fetch_control_inst (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .pc          (pc),
        .hit         (hit),
        .busy        (busy),
        .hit_inst    (hit_inst),
        .fill_done   (fill_done),
        .fill_data   (fill_data),
        .rresp       (rresp),
        .start_miss  (start_miss),
        .abort       (abort),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .fetch_error (fetch_error)
    );

    tag_store #(.INDEX_W(INDEX_W)) tag_store_inst (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .start_miss (start_miss),
        .fill_done  (fill_done),
        .fill_addr  (fill_addr),
        .hit        (hit),
        .hit_way    (hit_way),
        .fill_way   (fill_way)
    );

    data_store #(.INDEX_W(INDEX_W)) data_store_inst (
        .clk       (clk),
        .pc        (pc),
        .hit_way   (hit_way),
        .fill_done (fill_done),
        .fill_addr (fill_addr),
        .fill_way  (fill_way),
        .fill_data (fill_data),
        .hit_inst  (hit_inst)
    );

    miss_unit miss_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .abort      (abort),
        .start_miss (start_miss),
        .pc         (pc),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .busy       (busy),
        .fill_done  (fill_done),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data)
    );

endmodule

`default_nettype wire

// File: hw/line_array.sv
/*
 * per-set storage array, one write port and one combinational read port
 */

`timescale 1ns/100ps
`default_nettype none

module line_array #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 256
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] waddr,
    input  wire entry_t                   wdata,
    input  wire logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                        rdata
);

    entry_t mem [DEPTH];

    // contents are only trusted behind a valid bit
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: hw/miss_unit.sv
/*
 * line fill sequence on the read address and read data channels
 * one beat per line, reported as fill_done
 */

`timescale 1ns/100ps
`default_nettype none

module miss_unit import icache_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  abort,
    input  wire logic  start_miss,
    input  wire addr_t pc,
    input  wire logic  arready,
    input  wire logic  rvalid,
    input  wire fill_t rdata,
    output logic       arvalid,
    output addr_t      araddr,
    output logic       rready,
    output logic       busy,
    output logic       fill_done,
    output addr_t      fill_addr,
    output fill_t      fill_data
);

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_ADDR,
        MISS_DATA
    } miss_state_t;

    miss_state_t state_q;
    miss_state_t state_d;
    addr_t       line_addr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MISS_IDLE: if (start_miss) state_d = MISS_ADDR;
            MISS_ADDR: if (arready)    state_d = MISS_DATA;
            MISS_DATA: if (rvalid)     state_d = MISS_IDLE;
            default:                   state_d = MISS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || abort) begin
            state_q <= MISS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // line aligned fetch address
    always_ff @(posedge clk) begin
        if (start_miss) begin
            line_addr_q <= {pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

    assign arvalid   = (state_q == MISS_ADDR);
    assign rready    = (state_q == MISS_DATA);
    assign araddr    = line_addr_q;
    assign busy      = (state_q != MISS_IDLE);
    assign fill_done = rready && rvalid;
    assign fill_addr = line_addr_q;
    assign fill_data = rdata;

    // ========================================================================
    // bus and handoff checks
    a_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready && !abort |=> arvalid);

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
        start_miss |-> !busy);

endmodule

`default_nettype wire

// File: hw/tag_store.sv
/*
 * tag lookup for the two ways, valid bits and per-set victim bits
 * picks the way for the next fill
 */

`timescale 1ns/100ps
`default_nettype none

module tag_store import icache_pkg::*; #(
    parameter int INDEX_W = 8
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t pc,
    input  wire logic  start_miss,
    input  wire logic  fill_done,
    input  wire addr_t fill_addr,
    output logic       hit,
    output logic       hit_way,
    output logic       fill_way
);

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int DEPTH = 1 << INDEX_W;

    typedef logic [TAG_W-1:0] tag_t;

    logic [INDEX_W-1:0] pc_idx;
    logic [INDEX_W-1:0] fill_idx;
    tag_t               pc_tag;
    tag_t               fill_tag;
    tag_t               rd_tag [2];
    logic [1:0]         way_hit;

    logic [DEPTH-1:0]   valid_q [2];
    logic [DEPTH-1:0]   victim_q;

    assign pc_idx   = pc[OFFSET_W +: INDEX_W];
    assign pc_tag   = pc[ADDR_W-1 -: TAG_W];
    assign fill_idx = fill_addr[OFFSET_W +: INDEX_W];
    assign fill_tag = fill_addr[ADDR_W-1 -: TAG_W];

    // ========================================================================
    // tag arrays and compare
    for (genvar w = 0; w < 2; w++) begin : g_way
        line_array #(
            .entry_t (tag_t),
            .DEPTH   (DEPTH)
        ) tag_way_inst (
            .clk   (clk),
            .we    (fill_done && (fill_way == 1'(w))),
            .waddr (fill_idx),
            .wdata (fill_tag),
            .raddr (pc_idx),
            .rdata (rd_tag[w])
        );

        assign way_hit[w] = valid_q[w][pc_idx] && (rd_tag[w] == pc_tag);
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign fill_way = victim_q[fill_idx];

    // ========================================================================
    // valid and victim bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (fill_done) begin
            valid_q[fill_way][fill_idx] <= 1'b1;
        end
    end

    // invalid way first, otherwise alternate
    always_ff @(posedge clk) begin
        if (rst) begin
            victim_q <= '0;
        end else if (start_miss) begin
            if (!valid_q[0][pc_idx]) begin
                victim_q[pc_idx] <= 1'b0;
            end else if (!valid_q[1][pc_idx]) begin
                victim_q[pc_idx] <= 1'b1;
            end else begin
                victim_q[pc_idx] <= !victim_q[pc_idx];
            end
        end
    end

    // a line is only ever filled into one way of its set
    a_single_way_hit: assert property (@(posedge clk) disable iff (rst) !(&way_hit));

endmodule

`default_nettype wire

// File: verif/tb_bus_model.svh
/*
 * testbench helpers: galois LFSR, backing memory pattern
 * and the reference model of the valid, tag and victim state
 */

    localparam logic [31:0] LFSR_SEED = 32'hce60_20ff;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic [31:0]  lfsr_state = LFSR_SEED;
    logic [255:0] m_valid [2];
    logic [255:0] m_victim;
    logic [20:0]  m_tag [2][256];

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // n random bits, one LFSR step per bit
    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // every address bit goes into the word
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [63:0] line_at(input logic [31:0] line_addr);
        return {word_at(line_addr + 32'd4), word_at(line_addr)};
    endfunction

    task automatic model_reset();
        m_valid[0] = '0;
        m_valid[1] = '0;
        m_victim   = '0;
    endtask

    function automatic logic model_hit(input logic [31:0] a);
        logic [7:0]  idx;
        logic [20:0] tag;
        idx = a[10:3];
        tag = a[31:11];
        return (m_valid[0][idx] && (m_tag[0][idx] == tag))
            || (m_valid[1][idx] && (m_tag[1][idx] == tag));
    endfunction

    // invalid way first, otherwise the way opposite the victim bit
    task automatic model_fill(input logic [31:0] a);
        logic [7:0] idx;
        logic       way;
        idx = a[10:3];
        if (!m_valid[0][idx]) begin
            way = 1'b0;
        end else if (!m_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = !m_victim[idx];
        end
        m_victim[idx]     = way;
        m_valid[way][idx] = 1'b1;
        m_tag[way][idx]   = a[31:11];
    endtask

// File: verif/tb_icache_top.sv
/*
 * testbench for the instruction cache: clock, reset, stimulus,
 * bus responder, checks against the reference model and the summary
 */

`timescale 1ns/100ps
`default_nettype none

module tb_icache_top;

    localparam int          NUM_FETCH    = 400;
    localparam int          NUM_DIRECTED = 13;
    localparam int          MAX_CYCLES   = 40 * NUM_FETCH;
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;
    // tag selectors of the replacement sequence, first fetch in the low bits
    localparam logic [19:0] REPL_ORDER   =
        {2'd1, 2'd0, 2'd2, 2'd2, 2'd0, 2'd1, 2'd2, 2'd0, 2'd1, 2'd0};

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] pc;
    logic        stall;
    logic        flush;
    logic        arready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        rready;
    logic        rvalid;
    logic [1:0]  rresp;
    logic [63:0] rdata;
    logic [31:0] inst;
    logic        inst_valid;
    logic        fetch_error;

    // responder settings for the current fetch
    logic [1:0]  ar_delay;
    logic [1:0]  r_delay;
    logic        err_next;

    int errors  = 0;
    int cycles  = 0;
    int n_fetch = 0;
    int n_hit   = 0;
    int n_miss  = 0;

    `include "tb_bus_model.svh"

    icache_top #(.INDEX_W(8)) icache_top_inst (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .stall       (stall),
        .flush       (flush),
        .arready     (arready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .rready      (rready),
        .rvalid      (rvalid),
        .rresp       (rresp),
        .rdata       (rdata),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .fetch_error (fetch_error)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: no result after %0d cycles, %0d errors so far", cycles, errors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // inputs change 10 ns after the rising edge, outputs are sampled there too
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    function automatic logic [20:0] pool_tag(input logic [1:0] k);
        case (k)
            2'd0:    return 21'h0_0012;
            2'd1:    return 21'h1_a4c3;
            2'd2:    return 21'h0_f0f0;
            default: return 21'h1_5555;
        endcase
    endfunction

    task automatic do_fetch(input logic [31:0] addr, input int stall_cycles, input string name);
        logic [31:0] r;
        logic        exp_hit;
        logic        got_miss;
        int          low_cycles;
        rand_bits(2, r);
        ar_delay = r[1:0];
        rand_bits(2, r);
        r_delay = r[1:0];
        rand_bits(3, r);
        err_next = (r[2:0] == 3'd0);
        pc = addr;
        for (int i = 0; i < stall_cycles; i++) begin
            stall = 1'b1;
            step();
            if (!inst_valid || arvalid) begin
                $display("fetch started while stalled in %s at pc %h", name, addr);
                errors++;
            end
        end
        stall = 1'b0;
        exp_hit = model_hit(addr);
        step();
        n_fetch++;
        if (inst_valid) begin
            $display("fetch not accepted in %s at pc %h", name, addr);
            errors++;
        end
        got_miss = arvalid;
        if (got_miss != !exp_hit) begin
            report_mismatch({name, " miss"}, 32'(!exp_hit), 32'(got_miss));
        end
        if (got_miss && (araddr != {addr[31:3], 3'b000})) begin
            report_mismatch({name, " araddr"}, {addr[31:3], 3'b000}, araddr);
        end
        low_cycles = 1;
        while (!inst_valid) begin
            step();
            if (!inst_valid) begin
                low_cycles++;
            end
            if (!got_miss && arvalid) begin
                $display("bus read issued during a hit in %s at pc %h", name, addr);
                errors++;
            end
        end
        if (!got_miss && (low_cycles != 1)) begin
            report_mismatch({name, " hit latency"}, 32'd1, low_cycles);
        end
        if (inst != word_at({addr[31:2], 2'b00})) begin
            report_mismatch({name, " inst"}, word_at({addr[31:2], 2'b00}), inst);
        end
        if (!exp_hit) begin
            model_fill(addr);
        end
        if (got_miss) begin
            n_miss++;
            if (fetch_error != err_next) begin
                report_mismatch({name, " fetch_error"}, 32'(err_next), 32'(fetch_error));
            end
        end else begin
            n_hit++;
        end
    endtask

    // ========================================================================
    // bus responder, random delays on both channels
    initial begin : bus_responder
        logic [31:0] line_addr;
        arready = 1'b0;
        rvalid  = 1'b0;
        rresp   = 2'b00;
        rdata   = '0;
        forever begin
            step();
            if (arvalid) begin
                repeat (ar_delay) step();
                arready   = 1'b1;
                line_addr = araddr;
                step();
                arready = 1'b0;
                repeat (r_delay) step();
                rvalid = 1'b1;
                rdata  = line_at(line_addr);
                rresp  = err_next ? 2'b10 : 2'b00;
                step();
                rvalid = 1'b0;
                rresp  = 2'b00;
            end
        end
    end

    // ========================================================================
    // stimulus
    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [1:0]  sel;
        rst   = 1'b1;
        pc    = '0;
        stall = 1'b0;
        flush = 1'b0;
        model_reset();
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        if (!inst_valid || arvalid || rready || fetch_error) begin
            $display("wrong state after reset: inst_valid %b arvalid %b rready %b fetch_error %b",
                     inst_valid, arvalid, rready, fetch_error);
            errors++;
        end
        if (inst != NOP_WORD) begin
            report_mismatch("reset inst", NOP_WORD, inst);
        end

        // three lines in one set
        for (int i = 0; i < 10; i++) begin
            sel = 2'(REPL_ORDER >> (2 * i));
            a   = {pool_tag(sel), 8'h5a, i[0], 2'b00};
            do_fetch(a, 0, "replacement");
        end

        // flush while the hit is pending
        a = {pool_tag(2'd3), 8'h33, 1'b1, 2'b00};
        do_fetch(a, 0, "flush prime");
        pc = a;
        step();
        n_fetch++;
        if (inst_valid || arvalid) begin
            $display("flush fetch at pc %h did not go to the hit pending state", a);
            errors++;
        end
        flush = 1'b1;
        step();
        flush = 1'b0;
        if (inst != NOP_WORD) begin
            report_mismatch("flush inst", NOP_WORD, inst);
        end
        if (!inst_valid) begin
            report_mismatch("flush inst_valid", 32'd1, 32'(inst_valid));
        end
        do_fetch(a, 0, "flush refetch");

        for (int i = 0; i < NUM_FETCH - NUM_DIRECTED; i++) begin
            rand_bits(2, r);
            a[31:11] = pool_tag(r[1:0]);
            rand_bits(4, r);
            a[10:0] = {5'b00000, r[3:0], 2'b00};
            rand_bits(2, r);
            do_fetch(a, int'(r[1:0]), "random");
        end

        $display("summary: %0d fetches, %0d hits, %0d misses, %0d errors",
                 n_fetch, n_hit, n_miss, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
